// ==== bench/core_properties.sv ====
// Protocol assertions on the core's top-level strobes; bound into every core_top instance
module core_properties (
	input logic                clock,
	input logic                reset,
	input logic                i_instr_valid,
	input logic                i_accept,
	input logic                i_wb_valid,
	input core_pkg::reg_addr_t i_wb_rd,
	input logic                i_illegal
);
	timeunit 1ns;
	timeprecision 1ps;

	int unsigned fail_count = 0;

	// Accept only answers a presented instruction
	accept_needs_valid: assert property (@(posedge clock) disable iff (reset)
		i_accept |-> i_instr_valid)
		else begin
			fail_count++;
			$error("accept without a valid instruction");
		end

	wb_on_accept: assert property (@(posedge clock) disable iff (reset)
		i_wb_valid |-> (i_accept && (i_wb_rd != 5'd0)))  // x0 never written back
		else begin
			fail_count++;
			$error("write-back outside accept or to x0");
		end

	illegal_no_wb: assert property (@(posedge clock) disable iff (reset)
		!(i_illegal && i_wb_valid))
		else begin
			fail_count++;
			$error("illegal instruction wrote back");
		end

	quiet_in_reset: assert property (@(posedge clock)
		reset |=> (!i_accept && !i_wb_valid && !i_illegal))
		else begin
			fail_count++;
			$error("strobe active during reset");
		end

endmodule

bind core_top core_properties props0 (
	.clock(clock), .reset(reset), .i_instr_valid(i_instr_valid),
	.i_accept(o_instr_accept), .i_wb_valid(o_wb_valid), .i_wb_rd(o_wb_rd),
	.i_illegal(o_illegal)
);

// ==== bench/core_tb.sv ====
// Testbench for core_top; plays the fetch side, models each instruction and checks every retirement
module core_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import core_pkg::*;

	localparam int         CLK_PERIOD = 8;
	localparam addr_t      RESET_PC   = 32'h0000_1000;
	localparam int         N_INSTR    = 2 + 71 + 24 + 20 + 8 + 8;
	localparam int         MAX_LAT    = 34;  // Shift by 31 plus decode and write-back
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_IMM    = 7'b0010011;

	typedef struct packed {
		logic      wb;
		reg_addr_t rd;
		word_t     data;
		addr_t     pc;   // Next program counter
		logic      ill;
	} expect_t;

	logic      clock;
	logic      reset;
	logic      i_instr_valid;
	word_t     i_instr;
	logic      o_instr_accept;
	addr_t     o_pc;
	logic      o_wb_valid;
	reg_addr_t o_wb_rd;
	word_t     o_wb_data;
	logic      o_illegal;

	integer    seed = 54448;
	int        checks = 0;
	int        errors = 0;
	word_t     model_regs [NUM_REGS];
	addr_t     model_pc;
	expect_t   exp_q [$];   // One entry per instruction in flight
	string     name_q [$];

	core_top #(.RESET_PC(RESET_PC)) dut0 (
		.clock(clock), .reset(reset),
		.i_instr_valid(i_instr_valid), .i_instr(i_instr), .o_instr_accept(o_instr_accept),
		.o_pc(o_pc), .o_wb_valid(o_wb_valid), .o_wb_rd(o_wb_rd), .o_wb_data(o_wb_data),
		.o_illegal(o_illegal)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	function automatic int unsigned rand_below(input int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic reg_addr_t rand_reg();
		return reg_addr_t'(rand_below(32));
	endfunction

	function automatic word_t rand_word();
		return word_t'($random(seed));
	endfunction

	// Instruction encoders slice their immediates from a full word
	function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2, input reg_addr_t rs1,
		input logic [2:0] f3, input reg_addr_t rd, input logic [6:0] opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic word_t enc_i(input word_t imm, input reg_addr_t rs1, input logic [2:0] f3,
		input reg_addr_t rd, input logic [6:0] opc);
		return {imm[11:0], rs1, f3, rd, opc};
	endfunction

	function automatic word_t enc_u(input word_t imm, input reg_addr_t rd, input logic [6:0] opc);
		return {imm[31:12], rd, opc};
	endfunction

	function automatic word_t enc_b(input word_t imm, input reg_addr_t rs2, input reg_addr_t rs1,
		input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic word_t enc_j(input word_t imm, input reg_addr_t rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	// Expected retirement under RV32I rules for the supported subset and illegal for the rest
	function automatic expect_t ref_model(input word_t instr, input word_t regs [NUM_REGS],
		input addr_t pc);
		expect_t    e;
		word_t      a;
		word_t      b;
		word_t      res;
		word_t      imm_i;
		word_t      imm_b;
		word_t      imm_j;
		logic [2:0] f3;
		logic       writes;
		logic       taken;
		a      = regs[instr[19:15]];
		b      = regs[instr[24:20]];
		f3     = instr[14:12];
		imm_i  = {{20{instr[31]}}, instr[31:20]};
		imm_b  = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
		imm_j  = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
		writes = 1'b1;
		taken  = 1'b0;
		res    = '0;
		e.pc   = pc + 32'd4;
		e.ill  = 1'b0;
		case (instr[6:0])
			OPC_OP, OPC_IMM: begin
				if (instr[6:0] == OPC_IMM) begin
					b = (f3[1:0] == 2'b01) ? {27'b0, instr[24:20]} : imm_i;
				end
				case (f3)
					3'd0: res = (instr[5] && instr[30]) ? a - b : a + b;  // SUB only in R form
					3'd1: res = a << b[4:0];
					3'd2: res = {31'b0, $signed(a) < $signed(b)};
					3'd3: res = {31'b0, a < b};
					3'd4: res = a ^ b;
					3'd5: begin
						if (instr[30]) begin
							res = $signed(a) >>> b[4:0];
						end else begin
							res = a >> b[4:0];
						end
					end
					3'd6: res = a | b;
					default: res = a & b;
				endcase
			end
			7'b0110111: res = {instr[31:12], 12'h000};
			7'b0010111: res = pc + {instr[31:12], 12'h000};
			7'b1100011: begin
				writes = 1'b0;
				case (f3)
					3'd0: taken = (a == b);
					3'd1: taken = (a != b);
					3'd4: taken = ($signed(a) < $signed(b));
					3'd5: taken = ($signed(a) >= $signed(b));
					3'd6: taken = (a < b);
					3'd7: taken = (a >= b);
					default: e.ill = 1'b1;
				endcase
				if (taken) e.pc = pc + imm_b;
			end
			7'b1101111: begin
				res  = pc + 32'd4;
				e.pc = pc + imm_j;
			end
			7'b1100111: begin
				res  = pc + 32'd4;
				e.pc = (a + imm_i) & ~32'd1;
			end
			default: begin
				writes = 1'b0;
				e.ill  = 1'b1;
			end
		endcase
		e.wb   = writes && (instr[11:7] != 5'd0);
		e.rd   = instr[11:7];
		e.data = res;
		return e;
	endfunction

	function automatic word_t gen_arith();
		logic [2:0]  r_f3 [7] = '{3'd0, 3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
		logic [2:0]  i_f3 [6] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
		int unsigned k;
		k = rand_below(14);
		if (k < 7) begin
			return enc_r((k == 1) ? 7'h20 : 7'h00, rand_reg(), rand_reg(), r_f3[k],
				rand_reg(), OPC_OP);
		end else if (k < 13) begin
			return enc_i(rand_word(), rand_reg(), i_f3[k - 7], rand_reg(), OPC_IMM);
		end
		return enc_u(rand_word(), rand_reg(), rand_below(2) ? 7'b0110111 : 7'b0010111);
	endfunction

	function automatic word_t gen_shift();
		int unsigned k;
		logic [2:0]  f3;
		logic [6:0]  f7;
		k  = rand_below(6);
		f3 = (k % 3 == 0) ? 3'd1 : 3'd5;
		f7 = (k % 3 == 2) ? 7'h20 : 7'h00;  // Arithmetic right shift
		if (k < 3) return enc_r(f7, rand_reg(), rand_reg(), f3, rand_reg(), OPC_OP);
		return enc_i({20'b0, f7, rand_reg()}, rand_reg(), f3, rand_reg(), OPC_IMM);
	endfunction

	function automatic word_t gen_flow();
		logic [2:0]  b_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		reg_addr_t   rs1;
		int unsigned k;
		rs1 = rand_reg();
		k   = rand_below(4);
		case (k)
			0: return enc_b(rand_word(), rs1, rs1, b_f3[rand_below(6)]);  // Equal operands
			1: return enc_b(rand_word(), rand_reg(), rs1, b_f3[rand_below(6)]);
			2: return enc_j(rand_word(), rand_reg());
			default: return enc_i(rand_word(), rs1, 3'd0, rand_reg(), 7'b1100111);
		endcase
	endfunction

	task automatic check_value(input string name, input word_t expected, input word_t actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// Presents one instruction, holds it until accept, returns the cycles to accept
	task automatic run_instr(input string name, input word_t instr, output int cycles);
		expect_t e;
		e = ref_model(instr, model_regs, model_pc);
		exp_q.push_back(e);
		name_q.push_back(name);
		if (e.wb) model_regs[e.rd] = e.data;
		model_pc = e.pc;
		@(posedge clock);
		#1;
		i_instr_valid = 1'b1;
		i_instr       = instr;
		cycles        = 0;
		do begin
			@(posedge clock);
			#1;
			cycles++;
		end while (!o_instr_accept && cycles < MAX_LAT + 4);
		if (!o_instr_accept) begin
			errors++;
			$display("%s: the core did not accept the instruction in %0d cycles", name, cycles);
		end
		@(posedge clock);
		#1;
		i_instr_valid = 1'b0;
	endtask

	task automatic report_test(input string name, input int start_err);
		$display("%-8s finished with %0d errors", name, errors - start_err);
	endtask

	// Compares each retirement against the queued model result
	initial begin
		expect_t e;
		string   nm;
		forever begin
			@(negedge clock);
			if (o_instr_accept === 1'b1) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("The core accepted an instruction that was never presented");
				end else begin
					e  = exp_q.pop_front();
					nm = name_q.pop_front();
					check_value({nm, " wb_valid"}, e.wb, o_wb_valid);
					check_value({nm, " illegal"}, e.ill, o_illegal);
					check_value({nm, " pc"}, e.pc, o_pc);
					if (e.wb) begin
						check_value({nm, " wb_rd"}, e.rd, o_wb_rd);
						check_value({nm, " wb_data"}, e.data, o_wb_data);
					end
				end
			end
		end
	end

	initial begin
		logic [6:0] ill_opc [4];
		int         start_err;
		int         cycles;
		word_t      w;
		ill_opc       = '{7'b0000011, 7'b0100011, 7'b1110011, 7'b0001111};
		reset         = 1'b1;
		i_instr_valid = 1'b0;
		i_instr       = '0;
		model_pc      = RESET_PC;
		foreach (model_regs[i]) model_regs[i] = '0;
		repeat (10) @(posedge clock);
		#1;
		reset = 1'b0;

		start_err = errors;
		check_value("reset accept", 0, o_instr_accept);
		check_value("reset wb_valid", 0, o_wb_valid);
		check_value("reset illegal", 0, o_illegal);
		check_value("reset pc", RESET_PC, o_pc);
		run_instr("reset add x0", enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd1, OPC_OP), cycles);
		run_instr("reset add regs", enc_r(7'h00, 5'd13, 5'd7, 3'd0, 5'd2, OPC_OP), cycles);
		report_test("reset", start_err);

		start_err = errors;
		for (int i = 1; i < NUM_REGS; i++) begin  // Seed registers with LUI
			run_instr($sformatf("lui[%0d]", i),
				enc_u(rand_word(), reg_addr_t'(i), 7'b0110111), cycles);
		end
		for (int i = 0; i < 40; i++) run_instr($sformatf("arith[%0d]", i), gen_arith(), cycles);
		report_test("arith", start_err);

		start_err = errors;
		for (int i = 0; i < 24; i++) run_instr($sformatf("shift[%0d]", i), gen_shift(), cycles);
		report_test("shift", start_err);

		start_err = errors;
		for (int i = 0; i < 20; i++) run_instr($sformatf("flow[%0d]", i), gen_flow(), cycles);
		report_test("flow", start_err);

		start_err = errors;
		for (int i = 0; i < 8; i++) begin
			w      = rand_word();
			w[6:0] = ill_opc[i % 4];
			run_instr($sformatf("illegal[%0d]", i), w, cycles);
		end
		report_test("illegal", start_err);

		start_err = errors;
		for (int i = 0; i < 8; i++) begin
			run_instr($sformatf("latency[%0d]", i), gen_arith(), cycles);
			check_value($sformatf("latency[%0d] cycles", i), 2, cycles);
		end
		report_test("latency", start_err);

		errors += dut0.props0.fail_count;
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	initial begin
		#(CLK_PERIOD * (N_INSTR * MAX_LAT + 200));
		$display("Watchdog expired: the core stopped accepting instructions");
		$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== files.f ====
src/core_pkg.sv
src/decode_exec_if.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_shifter.sv
src/core_ctrl.sv
src/core_top.sv
bench/core_properties.sv
bench/core_tb.sv

// ==== src/core_ctrl.sv ====
// Execute sequencing, write-back and program counter update for one instruction at a time
module core_ctrl #(
	parameter core_pkg::addr_t RESET_PC = '0
) (
	input  logic                clock,
	input  logic                reset,
	decode_exec_if.ctl          dx,
	input  core_pkg::word_t     i_alu_result,
	input  logic                i_alu_cond,
	input  core_pkg::word_t     i_shift_result,
	input  logic                i_shift_busy,
	output logic                o_shift_start,
	output logic                o_wr_en,
	output core_pkg::reg_addr_t o_wr_addr,
	output core_pkg::word_t     o_wr_data,
	output core_pkg::addr_t     o_pc,
	output logic                o_wb_valid,
	output logic                o_illegal
);
	import core_pkg::*;

	ctrl_state_t state;
	logic        finish;   // Result ready this cycle
	logic        writes;   // Instruction class has a destination
	word_t       wb_data;
	addr_t       pc_plus4;
	addr_t       next_pc;
	addr_t       pc_q;
	logic        wr_en_q;
	logic        illegal_q;

	assign o_shift_start = (state == CTRL_IDLE) && dx.dec_valid
		&& (dx.op_type == OP_TYPE_SHIFT);
	assign finish = ((state == CTRL_IDLE) && dx.dec_valid && (dx.op_type != OP_TYPE_SHIFT))
		|| ((state == CTRL_WAIT_SHIFT) && !i_shift_busy);

	assign pc_plus4 = pc_q + 32'd4;
	assign writes   = (dx.op_type == OP_TYPE_ARITH) || (dx.op_type == OP_TYPE_SHIFT)
		|| (dx.op_type == OP_TYPE_JUMP);

	always_comb begin
		case (dx.op_type)
			OP_TYPE_SHIFT: wb_data = i_shift_result;
			OP_TYPE_JUMP:  wb_data = pc_plus4;  // Link address
			default:       wb_data = i_alu_result;
		endcase
	end

	always_comb begin
		case (dx.op_type)
			OP_TYPE_BRANCH: next_pc = i_alu_cond ? (pc_q + dx.op_c) : pc_plus4;
			OP_TYPE_JUMP: begin
				if (dx.is_jalr) begin
					next_pc = (dx.op_a + dx.op_c) & ~32'd1;
				end else begin
					next_pc = pc_q + dx.op_c;
				end
			end
			default: next_pc = pc_plus4;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state     <= CTRL_IDLE;
			pc_q      <= RESET_PC;
			wr_en_q   <= 1'b0;
			illegal_q <= 1'b0;
		end else begin
			case (state)
				CTRL_IDLE: begin
					if (o_shift_start) state <= CTRL_WAIT_SHIFT;
					else if (finish) state <= CTRL_EXEC;
				end
				CTRL_WAIT_SHIFT: begin
					if (finish) state <= CTRL_EXEC;
				end
				default: state <= CTRL_IDLE;  // EXEC lasts one cycle
			endcase
			wr_en_q   <= finish && writes && (dx.rd != '0);
			illegal_q <= finish && (dx.op_type == OP_TYPE_ILLEGAL);
			if (finish) pc_q <= next_pc;
		end
	end

	always_ff @(posedge clock) begin
		if (finish) begin
			o_wr_addr <= dx.rd;
			o_wr_data <= wb_data;
		end
	end

	assign dx.exec_done = (state == CTRL_EXEC);
	assign o_wr_en      = wr_en_q;
	assign o_wb_valid   = wr_en_q;
	assign o_illegal    = illegal_q;
	assign o_pc         = pc_q;

endmodule

// ==== src/core_pkg.sv ====
// Shared vector types and enums for the RV32I core; imported by every RTL file
package core_pkg;

	typedef logic [31:0] word_t;      // Data, operand or instruction word
	typedef logic [31:0] addr_t;      // Program counter value
	typedef logic [4:0]  reg_addr_t;  // Register number x0..x31
	typedef logic [4:0]  shamt_t;     // Shift amount

	// Architectural register count
	localparam int NUM_REGS = 32;

	// Operation selected by the decoder
	typedef enum logic [3:0] {
		OP_ADD = 4'd0,
		OP_SUB = 4'd1,
		OP_LT  = 4'd2,   // Signed compare
		OP_LTU = 4'd3,
		OP_XOR = 4'd4,
		OP_OR  = 4'd5,
		OP_AND = 4'd6,
		OP_OPA = 4'd7,   // Pass operand a
		OP_EQ  = 4'd8,
		OP_NE  = 4'd9,
		OP_GE  = 4'd10,
		OP_GEU = 4'd11,
		OP_SLL = 4'd12,
		OP_SRL = 4'd13,
		OP_SRA = 4'd14
	} op_t;

	// Class of instruction, picks the execute path
	typedef enum logic [2:0] {
		OP_TYPE_ARITH   = 3'd0,
		OP_TYPE_SHIFT   = 3'd1,  // Multi-cycle
		OP_TYPE_BRANCH  = 3'd2,
		OP_TYPE_JUMP    = 3'd3,
		OP_TYPE_ILLEGAL = 3'd4
	} op_type_t;

	// Decoder FSM
	typedef enum logic {
		DEC_DECODE = 1'b0,  // Waiting for an instruction
		DEC_HOLD   = 1'b1   // Operands held until execute finishes
	} dec_state_t;

	// Control FSM
	typedef enum logic [1:0] {
		CTRL_IDLE       = 2'd0,
		CTRL_EXEC       = 2'd1,  // Result registered, accept pulses
		CTRL_WAIT_SHIFT = 2'd2
	} ctrl_state_t;

endpackage

// ==== src/core_top.sv ====
// Multi-cycle RV32I core; fetch logic presents instructions and watches the write-back port
module core_top #(
	parameter core_pkg::addr_t RESET_PC = '0
) (
	input  logic                clock,
	input  logic                reset,
	input  logic                i_instr_valid,
	input  core_pkg::word_t     i_instr,
	output logic                o_instr_accept,
	output core_pkg::addr_t     o_pc,
	output logic                o_wb_valid,
	output core_pkg::reg_addr_t o_wb_rd,
	output core_pkg::word_t     o_wb_data,
	output logic                o_illegal
);
	import core_pkg::*;

	reg_addr_t ra_addr;
	reg_addr_t rb_addr;
	word_t     ra_data;
	word_t     rb_data;
	logic      wr_en;
	word_t     alu_result;
	logic      alu_cond;
	word_t     shift_result;
	logic      shift_busy;
	logic      shift_start;

	decode_exec_if dx ();

	rv_decode u_decode (
		.i_clock(clock), .i_reset(reset),
		.i_instr_valid(i_instr_valid), .i_instr(i_instr), .i_pc(o_pc),
		.o_ra_addr(ra_addr), .o_rb_addr(rb_addr),
		.i_ra_data(ra_data), .i_rb_data(rb_data),
		.dx(dx.dec)
	);

	rv_regfile u_regfile (
		.clock(clock), .reset(reset),
		.i_ra_addr(ra_addr), .i_rb_addr(rb_addr),
		.o_ra_data(ra_data), .o_rb_data(rb_data),
		.i_wr_en(wr_en), .i_wr_addr(o_wb_rd), .i_wr_data(o_wb_data)
	);

	rv_alu u_alu (.dx(dx.exe), .o_result(alu_result), .o_cond(alu_cond));

	rv_shifter u_shifter (
		.clock(clock), .reset(reset), .i_start(shift_start), .dx(dx.exe),
		.o_busy(shift_busy), .o_result(shift_result)
	);

	core_ctrl #(.RESET_PC(RESET_PC)) u_ctrl (
		.clock(clock), .reset(reset), .dx(dx.ctl),
		.i_alu_result(alu_result), .i_alu_cond(alu_cond),
		.i_shift_result(shift_result), .i_shift_busy(shift_busy),
		.o_shift_start(shift_start),
		.o_wr_en(wr_en), .o_wr_addr(o_wb_rd), .o_wr_data(o_wb_data),
		.o_pc(o_pc), .o_wb_valid(o_wb_valid), .o_illegal(o_illegal)
	);

	assign o_instr_accept = dx.exec_done;  // Fetch may move on next cycle

endmodule

// ==== src/decode_exec_if.sv ====
// Bundle between decoder, execute units and control; one instance lives in core_top
interface decode_exec_if;
	import core_pkg::*;

	logic      dec_valid;  // Level, high while an instruction waits for execute
	word_t     op_a;
	word_t     op_b;
	word_t     op_c;       // Branch or jump offset
	op_t       op;
	op_type_t  op_type;
	reg_addr_t rd;
	logic      is_jalr;
	logic      exec_done;  // Single-cycle pulse from control

	modport dec (
		output dec_valid, op_a, op_b, op_c, op, op_type, rd, is_jalr,
		input  exec_done
	);

	modport exe (input op_a, op_b, op);

	modport ctl (
		input  dec_valid, op_a, op_b, op_c, op, op_type, rd, is_jalr,
		output exec_done
	);

endinterface

// ==== src/rv_alu.sv ====
// Combinational ALU for arithmetic, logic, set-less-than and branch compares
module rv_alu (
	decode_exec_if.exe      dx,
	output core_pkg::word_t o_result,
	output logic            o_cond    // Branch taken
);
	import core_pkg::*;

	logic eq;
	logic lt;
	logic ltu;

	assign eq  = (dx.op_a == dx.op_b);
	assign lt  = ($signed(dx.op_a) < $signed(dx.op_b));
	assign ltu = (dx.op_a < dx.op_b);

	always_comb begin
		case (dx.op)
			OP_ADD:  o_result = dx.op_a + dx.op_b;
			OP_SUB:  o_result = dx.op_a - dx.op_b;
			OP_LT:   o_result = {31'b0, lt};
			OP_LTU:  o_result = {31'b0, ltu};
			OP_XOR:  o_result = dx.op_a ^ dx.op_b;
			OP_OR:   o_result = dx.op_a | dx.op_b;
			OP_AND:  o_result = dx.op_a & dx.op_b;
			OP_OPA:  o_result = dx.op_a;  // LUI
			default: o_result = '0;
		endcase
	end

	always_comb begin
		case (dx.op)
			OP_EQ:   o_cond = eq;
			OP_NE:   o_cond = !eq;
			OP_LT:   o_cond = lt;
			OP_GE:   o_cond = !lt;
			OP_LTU:  o_cond = ltu;
			OP_GEU:  o_cond = !ltu;
			default: o_cond = 1'b0;
		endcase
	end

endmodule

// ==== src/rv_decode.sv ====
// RV32I decoder; captures an instruction from the fetch side and presents operands to execute
module rv_decode (
	input  logic                i_clock,
	input  logic                i_reset,
	input  logic                i_instr_valid,
	input  core_pkg::word_t     i_instr,     // Held stable by fetch until accept
	input  core_pkg::addr_t     i_pc,
	output core_pkg::reg_addr_t o_ra_addr,
	output core_pkg::reg_addr_t o_rb_addr,
	input  core_pkg::word_t     i_ra_data,
	input  core_pkg::word_t     i_rb_data,
	decode_exec_if.dec          dx
);
	import core_pkg::*;

	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;

	// Instruction formats
	localparam logic [2:0] FMT_R = 3'd0;
	localparam logic [2:0] FMT_I = 3'd1;
	localparam logic [2:0] FMT_U = 3'd2;
	localparam logic [2:0] FMT_B = 3'd3;
	localparam logic [2:0] FMT_J = 3'd4;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [2:0] fmt;
	op_type_t   op_type_w;
	word_t      imm_i;
	word_t      imm_b;
	word_t      imm_j;

	dec_state_t state;
	reg_addr_t  rd_q;
	op_type_t   op_type_q;
	word_t      imm_upper_q;

	assign opcode = i_instr[6:0];
	assign funct3 = i_instr[14:12];

	assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
	assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
		i_instr[11:8], 1'b0};
	assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
		i_instr[30:21], 1'b0};

	// Register reads follow the instruction directly
	assign o_ra_addr = i_instr[19:15];
	assign o_rb_addr = i_instr[24:20];

	always_comb begin
		fmt       = FMT_R;
		op_type_w = OP_TYPE_ILLEGAL;  // Loads, stores, system, unknown
		case (opcode)
			OPC_OP, OPC_OP_IMM: begin
				fmt = (opcode == OPC_OP) ? FMT_R : FMT_I;
				op_type_w = (funct3[1:0] == 2'b01) ? OP_TYPE_SHIFT : OP_TYPE_ARITH;
			end
			OPC_LUI, OPC_AUIPC: begin
				fmt       = FMT_U;
				op_type_w = OP_TYPE_ARITH;
			end
			OPC_BRANCH: begin
				fmt = FMT_B;
				// funct3 010 and 011 are not branches
				op_type_w = (funct3[2:1] == 2'b01) ? OP_TYPE_ILLEGAL : OP_TYPE_BRANCH;
			end
			OPC_JAL: begin
				fmt       = FMT_J;
				op_type_w = OP_TYPE_JUMP;
			end
			OPC_JALR: begin
				fmt       = FMT_I;
				op_type_w = OP_TYPE_JUMP;
			end
			default: ;
		endcase
	end

	// Operand selection
	always_comb begin
		case (fmt)
			FMT_U:   dx.op_a = imm_upper_q;
			FMT_J:   dx.op_a = i_pc;
			default: dx.op_a = i_ra_data;  // rs1
		endcase

		case (fmt)
			FMT_I:   dx.op_b = (op_type_q == OP_TYPE_SHIFT) ? {27'b0, i_instr[24:20]} : imm_i;
			FMT_U:   dx.op_b = i_instr[5] ? '0 : i_pc;  // LUI adds nothing, AUIPC adds pc
			FMT_J:   dx.op_b = '0;
			default: dx.op_b = i_rb_data;
		endcase

		case (fmt)
			FMT_B:   dx.op_c = imm_b;
			FMT_J:   dx.op_c = imm_j;
			FMT_I:   dx.op_c = imm_i;  // JALR offset
			default: dx.op_c = '0;
		endcase
	end

	// Operation from the captured type and the function fields
	always_comb begin
		dx.op = OP_ADD;
		case (op_type_q)
			OP_TYPE_ARITH: begin
				if (i_instr[2]) begin
					dx.op = i_instr[5] ? OP_OPA : OP_ADD;  // LUI or AUIPC
				end else begin
					case (funct3)
						3'b000:  dx.op = (i_instr[5] && i_instr[30]) ? OP_SUB : OP_ADD;
						3'b010:  dx.op = OP_LT;
						3'b011:  dx.op = OP_LTU;
						3'b100:  dx.op = OP_XOR;
						3'b110:  dx.op = OP_OR;
						default: dx.op = OP_AND;
					endcase
				end
			end
			OP_TYPE_SHIFT: begin
				if (funct3 == 3'b001) begin
					dx.op = OP_SLL;
				end else begin
					dx.op = i_instr[30] ? OP_SRA : OP_SRL;
				end
			end
			OP_TYPE_BRANCH: begin
				case (funct3)
					3'b000:  dx.op = OP_EQ;
					3'b001:  dx.op = OP_NE;
					3'b100:  dx.op = OP_LT;
					3'b101:  dx.op = OP_GE;
					3'b110:  dx.op = OP_LTU;
					default: dx.op = OP_GEU;
				endcase
			end
			default: ;
		endcase
	end

	assign dx.is_jalr   = (opcode == OPC_JALR);
	assign dx.rd        = rd_q;
	assign dx.op_type   = op_type_q;
	assign dx.dec_valid = (state == DEC_HOLD) && !dx.exec_done;  // Drops with exec_done

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state     <= DEC_DECODE;
			rd_q      <= '0;
			op_type_q <= OP_TYPE_ILLEGAL;
		end else begin
			case (state)
				DEC_DECODE: begin
					if (i_instr_valid) begin
						state       <= DEC_HOLD;
						rd_q        <= i_instr[11:7];
						op_type_q   <= op_type_w;
						imm_upper_q <= {i_instr[31:12], 12'h000};
					end
				end
				default: begin
					if (dx.exec_done) state <= DEC_DECODE;
				end
			endcase
		end
	end

endmodule

// ==== src/rv_regfile.sv ====
// General purpose registers x0..x31 with two combinational read ports and one write port
module rv_regfile (
	input  logic                clock,
	input  logic                reset,
	input  core_pkg::reg_addr_t i_ra_addr,
	input  core_pkg::reg_addr_t i_rb_addr,
	output core_pkg::word_t     o_ra_data,
	output core_pkg::word_t     o_rb_data,
	input  logic                i_wr_en,
	input  core_pkg::reg_addr_t i_wr_addr,
	input  core_pkg::word_t     i_wr_data
);
	import core_pkg::*;

	word_t regs [NUM_REGS];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wr_en && (i_wr_addr != '0)) begin
			regs[i_wr_addr] <= i_wr_data;  // x0 never written
		end
	end

	// x0 stays zero since it is never written
	assign o_ra_data = regs[i_ra_addr];
	assign o_rb_data = regs[i_rb_addr];

endmodule

// ==== src/rv_shifter.sv ====
// Serial shifter, one bit position per clock; busy stays high until the count runs out
module rv_shifter (
	input  logic            clock,
	input  logic            reset,
	input  logic            i_start,
	decode_exec_if.exe      dx,
	output logic            o_busy,
	output core_pkg::word_t o_result
);
	import core_pkg::*;

	word_t  value;
	shamt_t count;  // Bit positions left to shift

	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
		end else if (i_start) begin
			count <= dx.op_b[4:0];
		end else if (count != '0) begin
			count <= count - shamt_t'(1);
		end
	end

	// Direction comes from op, held by the decoder for the whole shift
	always_ff @(posedge clock) begin
		if (i_start) begin
			value <= dx.op_a;
		end else if (count != '0) begin
			case (dx.op)
				OP_SLL:  value <= {value[30:0], 1'b0};
				OP_SRA:  value <= {value[31], value[31:1]};  // Sign fill
				default: value <= {1'b0, value[31:1]};
			endcase
		end
	end

	assign o_busy   = (count != '0);
	assign o_result = value;

endmodule
